// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Address and instruction width
  localparam int unsigned XLEN = 32;

  // AXI read ID width
  localparam int unsigned ID_WIDTH = 4;

  // ----------------------------------------
  // Fetch constants
  // ----------------------------------------

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // One instruction word per fetch
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // Read ID expected back on every beat
  localparam logic [ID_WIDTH-1:0] FETCH_ID = '0;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // AXI4 RRESP encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Fetch sequencer states
  // One step per handshake, then back to idle
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    WAIT_ARREADY = 2'b01,
    WAIT_RVALID  = 2'b10,
    WAIT_READY   = 2'b11
  } fetch_state_e;

endpackage

`default_nettype wire

// File: rtl/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen
  import fetch_pkg::*;
(
  input  wire logic            clock,
  input  wire logic            reset,

  // Branch redirect strobe
  input  wire logic            redirect_i,
  input  wire logic [XLEN-1:0] redirect_pc_i,

  // Request handshake toward the controller
  input  wire logic            req_ready_i,
  output logic                 req_valid_o,
  output logic [XLEN-1:0]      req_pc_o
);

  // ----------------------------------------
  // Internal state
  // ----------------------------------------

  // Current fetch address
  logic [XLEN-1:0] pc_q;

  // Request flag, low only while in reset
  logic            valid_q;

  // Request accepted this cycle
  logic            req_fire;

  // Next sequential address
  logic [XLEN-1:0] pc_next_seq;

  assign req_fire    = valid_q && req_ready_i;
  assign pc_next_seq = pc_q + PC_STEP;

  // ----------------------------------------
  // Valid flag
  // ----------------------------------------

  // Always requesting once out of reset
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Program counter
  // ----------------------------------------

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      // Redirect wins over the step
      // A same-cycle handshake still carries the old pc
      pc_q <= redirect_pc_i;
    end else if (req_fire) begin
      pc_q <= pc_next_seq;
    end
  end

  // Held while the controller is busy
  assign req_valid_o = valid_q;
  assign req_pc_o    = pc_q;

endmodule

`default_nettype wire

// File: rtl/fetch_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_controller
  import fetch_pkg::*;
(
  input  wire logic clock,
  input  wire logic reset,

  // Request side, from pc_gen
  input  wire logic valid_pre_i,
  output logic      ready_pre_o,

  // Decode side
  output logic      valid_post_o,
  input  wire logic ready_post_i,

  // Datapath load strobes
  output logic      pc_we_o,
  output logic      inst_we_o,

  // AXI read address channel
  input  wire logic arready_i,
  output logic      arvalid_o,

  // AXI read data channel
  output logic      rready_o,
  input  wire logic rvalid_i
);

  // ----------------------------------------
  // State register
  // ----------------------------------------

  fetch_state_e state_q;
  fetch_state_e state_d;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  // One step per handshake, hold otherwise
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Take a new request
        if (valid_pre_i) begin
          state_d = WAIT_ARREADY;
        end
      end
      WAIT_ARREADY: begin
        // Address accepted by the slave
        if (arready_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        // Single data beat back
        if (rvalid_i) begin
          state_d = WAIT_READY;
        end
      end
      WAIT_READY: begin
        // Decode took the result
        if (ready_post_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // Handshake flags straight from the state
  assign ready_pre_o  = (state_q == IDLE);
  assign arvalid_o    = (state_q == WAIT_ARREADY);
  assign rready_o     = (state_q == WAIT_RVALID);
  assign valid_post_o = (state_q == WAIT_READY);

  // Address load on the request handshake
  assign pc_we_o   = valid_pre_i && ready_pre_o;

  // Instruction load on the data beat
  assign inst_we_o = rvalid_i && rready_o;

endmodule

`default_nettype wire

// File: rtl/fetch_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_datapath
  import fetch_pkg::*;
(
  input  wire logic                clock,
  input  wire logic                reset,

  // Load strobes from the controller
  input  wire logic                pc_we_i,
  input  wire logic                inst_we_i,

  // Request address from pc_gen
  input  wire logic [XLEN-1:0]     pc_i,

  // AXI read data fields
  input  wire logic [XLEN-1:0]     rdata_i,
  input  wire axi_resp_e           rresp_i,
  input  wire logic [ID_WIDTH-1:0] rid_i,
  input  wire logic                rlast_i,

  // Latched results
  output logic [XLEN-1:0]          araddr_o,
  output logic [XLEN-1:0]          inst_o,
  output logic                     fault_o
);

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  // Fetch address, also the pc seen by decode
  logic [XLEN-1:0] addr_q;

  // Returned instruction word
  logic [XLEN-1:0] inst_q;

  // Error flag for the latched beat
  logic            fault_q;

  // ----------------------------------------
  // Fault detection
  // ----------------------------------------

  logic resp_bad;
  logic id_bad;
  logic last_bad;
  logic beat_fault;

  // Anything but OKAY or EXOKAY is an error
  assign resp_bad = (rresp_i != OKAY) && (rresp_i != EXOKAY);

  // Beat belongs to another transaction
  assign id_bad   = (rid_i != FETCH_ID);

  // Single-beat read must carry RLAST
  assign last_bad = !rlast_i;

  assign beat_fault = resp_bad || id_bad || last_bad;

  // ----------------------------------------
  // Address register
  // ----------------------------------------

  // Stable from the request handshake to the next one
  always_ff @(posedge clock) begin
    if (pc_we_i) begin
      addr_q <= pc_i;
    end
  end

  // ----------------------------------------
  // Instruction register
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (inst_we_i) begin
      inst_q <= rdata_i;
    end
  end

  // Fault flag follows the same beat
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      fault_q <= 1'b0;
    end else if (inst_we_i) begin
      fault_q <= beat_fault;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign araddr_o = addr_q;
  assign inst_o   = inst_q;
  assign fault_o  = fault_q;

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  wire logic                clock,
  input  wire logic                reset,

  // Branch redirect
  input  wire logic                redirect_i,
  input  wire logic [XLEN-1:0]     redirect_pc_i,

  // AXI read address channel
  output logic [XLEN-1:0]          araddr_o,
  output logic                     arvalid_o,
  input  wire logic                arready_i,

  // AXI read data channel
  input  wire logic                rvalid_i,
  output logic                     rready_o,
  input  wire logic [XLEN-1:0]     rdata_i,
  input  wire axi_resp_e           rresp_i,
  input  wire logic [ID_WIDTH-1:0] rid_i,
  input  wire logic                rlast_i,

  // Decode handshake
  output logic                     valid_o,
  input  wire logic                ready_i,
  output logic [XLEN-1:0]          pc_o,
  output logic [XLEN-1:0]          inst_o,
  output logic                     fault_o
);

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------

  // pc_gen to controller handshake
  logic            req_valid;
  logic            req_ready;
  logic [XLEN-1:0] req_pc;

  // Controller to datapath strobes
  logic            pc_we;
  logic            inst_we;

  // Latched fetch address
  logic [XLEN-1:0] fetch_addr;

  // ----------------------------------------
  // Instances
  // ----------------------------------------

  pc_gen u_pc_gen (
    .clock         (clock),
    .reset         (reset),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .req_ready_i   (req_ready),
    .req_valid_o   (req_valid),
    .req_pc_o      (req_pc)
  );

  fetch_controller u_fetch_controller (
    .clock        (clock),
    .reset        (reset),
    .valid_pre_i  (req_valid),
    .ready_pre_o  (req_ready),
    .valid_post_o (valid_o),
    .ready_post_i (ready_i),
    .pc_we_o      (pc_we),
    .inst_we_o    (inst_we),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i)
  );

  fetch_datapath u_fetch_datapath (
    .clock     (clock),
    .reset     (reset),
    .pc_we_i   (pc_we),
    .inst_we_i (inst_we),
    .pc_i      (req_pc),
    .rdata_i   (rdata_i),
    .rresp_i   (rresp_i),
    .rid_i     (rid_i),
    .rlast_i   (rlast_i),
    .araddr_o  (fetch_addr),
    .inst_o    (inst_o),
    .fault_o   (fault_o)
  );

  // Same register feeds the bus and decode
  assign araddr_o = fetch_addr;
  assign pc_o     = fetch_addr;

endmodule

`default_nettype wire

// File: tests/axi_rom_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rom_model
  import fetch_pkg::*;
#(
  parameter logic [XLEN-1:0] ROM_PATTERN = '0,
  parameter logic [XLEN-1:0] FAULT_MASK  = '0,
  parameter int              MAX_STALL   = 0,
  parameter int              BAD_ID_BEAT = 0,
  parameter int              SEED        = 1
) (
  input  wire logic            clock,
  input  wire logic            reset,
  input  wire logic [XLEN-1:0] araddr_i,
  input  wire logic            arvalid_i,
  output logic                 arready_o,
  output logic                 rvalid_o,
  input  wire logic            rready_i,
  output logic [XLEN-1:0]      rdata_o,
  output axi_resp_e            rresp_o,
  output logic [ID_WIDTH-1:0]  rid_o,
  output logic                 rlast_o
);

  integer          seed;
  integer          stall;
  int              beat_idx;
  logic [XLEN-1:0] addr;

  // 0 to MAX_STALL idle cycles
  function automatic integer random_stall();
    return $unsigned($random(seed)) % (MAX_STALL + 1);
  endfunction

  // Slave outputs change only on the falling edge
  initial begin
    seed      = SEED;
    beat_idx  = 0;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = OKAY;
    rid_o     = FETCH_ID;
    rlast_o   = 1'b0;
    forever begin
      @(negedge clock);
      if (reset && arvalid_i) begin
        addr = araddr_i;
        // Address phase
        stall = random_stall();
        repeat (stall) @(negedge clock);
        arready_o = 1'b1;
        @(negedge clock);
        arready_o = 1'b0;
        // Data phase
        stall = random_stall();
        repeat (stall) @(negedge clock);
        rvalid_o = 1'b1;
        rdata_o  = addr ^ ROM_PATTERN;
        rresp_o  = ((addr & FAULT_MASK) == FAULT_MASK) ? SLVERR : OKAY;
        rid_o    = (beat_idx == BAD_ID_BEAT) ? FETCH_ID + 1'b1 : FETCH_ID;
        rlast_o  = 1'b1;
        // Beat held until the master raises rready
        while (!rready_i) @(negedge clock);
        @(negedge clock);
        rvalid_o = 1'b0;
        rresp_o  = OKAY;
        rid_o    = FETCH_ID;
        rlast_o  = 1'b0;
        beat_idx++;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit
  import fetch_pkg::*;
();

  // ----------------------------------------
  // Test constants
  // ----------------------------------------

  localparam logic [XLEN-1:0] ROM_PATTERN     = 32'hA5C3_0F96;
  // Fault when address bits [5:4] are both set
  localparam logic [XLEN-1:0] FAULT_MASK      = 32'h0000_0030;
  localparam logic [XLEN-1:0] REDIRECT_TARGET = 32'h0000_2000;
  localparam int NUM_FETCHES  = 40;
  localparam int MAX_STALL    = 3;
  localparam int BAD_ID_BEAT  = 5;
  localparam int REDIRECT_AT  = 20;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FETCHES * (2 * MAX_STALL + 8);

  logic clock, reset, redirect, arvalid, arready, rvalid, rready, rlast;
  logic valid, ready, fault;
  logic [XLEN-1:0] redirect_pc, araddr, rdata, pc, inst;
  logic [ID_WIDTH-1:0] rid;
  axi_resp_e rresp;

  // Reference tracking
  logic [XLEN-1:0] exp_addr = RESET_PC;
  logic [XLEN-1:0] issued_addr = '0;
  logic [XLEN-1:0] prev_araddr, prev_pc, prev_inst;
  // Handshake flags from the previous rising edge
  logic prev_arvalid = 1'b0;
  logic prev_arready = 1'b0;
  logic prev_valid   = 1'b0;
  logic prev_ready   = 1'b0;
  logic prev_fault, exp_fault;
  logic redirect_done = 1'b0;
  int result_count = 0;
  integer seed;

  fetch_unit dut (
    .clock(clock), .reset(reset), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
    .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rresp_i(rresp),
    .rid_i(rid), .rlast_i(rlast), .valid_o(valid), .ready_i(ready),
    .pc_o(pc), .inst_o(inst), .fault_o(fault)
  );

  axi_rom_model #(
    .ROM_PATTERN(ROM_PATTERN), .FAULT_MASK(FAULT_MASK), .MAX_STALL(MAX_STALL),
    .BAD_ID_BEAT(BAD_ID_BEAT), .SEED(67)
  ) u_rom (
    .clock(clock), .reset(reset), .araddr_i(araddr), .arvalid_i(arvalid),
    .arready_o(arready), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
    .rresp_o(rresp), .rid_o(rid), .rlast_o(rlast)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] expected);
    fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected));
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    fail_run("Watchdog timeout: fetches did not complete in time");
  end

  // ----------------------------------------
  // Checks sampled on the rising edge
  // ----------------------------------------

  always @(posedge clock) begin
    if (!reset) begin
      assert (!arvalid) else report_mismatch("arvalid_o", arvalid, 0);
      assert (!rready) else report_mismatch("rready_o", rready, 0);
      assert (!valid) else report_mismatch("valid_o", valid, 0);
    end else begin
      // Single outstanding fetch
      assert (!(valid && (arvalid || rready)))
        else fail_run("valid_o high while a bus transaction is still open");
      if (prev_arvalid && !prev_arready) begin
        // Address channel stall
        assert (arvalid) else report_mismatch("arvalid_o", arvalid, 1);
        assert (araddr == prev_araddr) else report_mismatch("araddr_o", araddr, prev_araddr);
      end else if (arvalid) begin
        // New transaction
        assert (araddr == exp_addr) else report_mismatch("araddr_o", araddr, exp_addr);
        issued_addr = exp_addr;
        exp_addr = exp_addr + PC_STEP;
      end
      // Next request starts from the redirect target
      if (redirect) begin
        exp_addr = redirect_pc;
      end
      if (prev_valid && !prev_ready) begin
        // Decode back-pressure
        assert (valid) else report_mismatch("valid_o", valid, 1);
        assert (pc == prev_pc) else report_mismatch("pc_o", pc, prev_pc);
        assert (inst == prev_inst) else report_mismatch("inst_o", inst, prev_inst);
        assert (fault == prev_fault) else report_mismatch("fault_o", fault, prev_fault);
        assert (!arvalid) else report_mismatch("arvalid_o", arvalid, 0);
      end
      if (valid && ready) begin
        // Result accepted by decode
        exp_fault = ((issued_addr & FAULT_MASK) == FAULT_MASK) || (result_count == BAD_ID_BEAT);
        assert (pc == issued_addr) else report_mismatch("pc_o", pc, issued_addr);
        assert (inst == (issued_addr ^ ROM_PATTERN))
          else report_mismatch("inst_o", inst, issued_addr ^ ROM_PATTERN);
        assert (fault == exp_fault) else report_mismatch("fault_o", fault, exp_fault);
        result_count++;
      end
    end
    prev_arvalid = arvalid;
    prev_arready = arready;
    prev_araddr  = araddr;
    prev_valid   = valid;
    prev_ready   = ready;
    prev_pc      = pc;
    prev_inst    = inst;
    prev_fault   = fault;
  end

  // ----------------------------------------
  // Stimulus driven on the falling edge
  // ----------------------------------------

  initial begin
    seed        = 67;
    reset       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    ready       = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b1;
    while (result_count < NUM_FETCHES) begin
      @(negedge clock);
      // Decode stalls about one cycle in four
      ready = (($random(seed) & 3) != 0);
      // Redirect only while a bus transaction is open
      if (!redirect_done && result_count >= REDIRECT_AT && (arvalid || rready)) begin
        redirect      = 1'b1;
        redirect_pc   = REDIRECT_TARGET;
        redirect_done = 1'b1;
      end else begin
        redirect = 1'b0;
      end
    end
    if (!redirect_done) begin
      fail_run("Redirect strobe was never issued");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/fetch_controller.sv
rtl/fetch_datapath.sv
rtl/fetch_unit.sv
tests/axi_rom_model.sv
tests/tb_fetch_unit.sv
